//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= sccb_cfg_tb
RTL_TOP   ?= sccb_cfg_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/cam_init_sequencer.sv
`timescale 1ns/1ns

module cam_init_sequencer (
	input  logic                  clk_25M,
	input  logic                  rst_n,
	input  logic                  wr_valid,
	input  sccb_pkg::sccb_write_t wr_req,
	output logic                  wr_ready,
	output logic                  req_valid,
	output sccb_pkg::sccb_write_t req,
	input  logic                  req_ready,
	output logic                  init_done
);
	import sccb_pkg::*;

	logic [INIT_IDX_W-1:0] idx;
	logic [TBL_IDX_W-1:0] tbl_idx;

	// Wraps to 0 once idx reaches INIT_LEN, but then the table is no longer selected
	assign tbl_idx = idx[TBL_IDX_W-1:0];

	assign init_done = (idx == INIT_IDX_W'(INIT_LEN));

	// Table entries first, then the external channel straight through
	assign req_valid = init_done ? wr_valid : 1'b1;
	assign req       = init_done ? wr_req : INIT_TABLE[tbl_idx];
	assign wr_ready  = init_done & req_ready;

	always_ff @(posedge clk_25M) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (!init_done && req_ready) begin
			idx <= idx + 1'b1; // Entry accepted by the controller
		end
	end

	// Index stops at INIT_LEN and stays there
	a_idx_range: assert property (
		@(posedge clk_25M) disable iff (!rst_n)
		idx <= INIT_IDX_W'(INIT_LEN)
	);

endmodule

//--- rtl/sccb_bit_timer.sv
`timescale 1ns/1ns

module sccb_bit_timer (
	input  logic        clk_25M,
	input  logic        rst_n,
	input  logic        start,
	input  logic [10:0] delay,
	output logic        done
);

	logic [10:0] cnt;
	logic running;

	always_ff @(posedge clk_25M) begin
		if (!rst_n) begin
			running <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
			end else if (running && cnt == 11'd0) begin
				running <= 1'b0; // Count passed zero
				done <= 1'b1;
			end
		end
	end

	// Down-counter, loaded on start
	always_ff @(posedge clk_25M) begin
		if (start)
			cnt <= delay;
		else if (running)
			cnt <= cnt - 11'd1;
	end

	a_no_restart: assert property (
		@(posedge clk_25M) disable iff (!rst_n)
		start |-> !running
	);

endmodule

//--- rtl/sccb_cfg_top.sv
`timescale 1ns/1ns

module sccb_cfg_top (
	input  logic                  clk_25M,
	input  logic                  rst_n,
	input  logic                  wr_valid,
	input  sccb_pkg::sccb_write_t wr_req,
	output logic                  wr_ready,
	output logic                  scl,
	output logic                  sda,
	output logic                  busy,
	output logic                  init_done
);
	import sccb_pkg::*;

	// Sequencer to controller
	logic req_valid;
	logic req_ready;
	sccb_write_t req;

	logic load;
	logic shift;
	logic cur_bit;
	logic last_bit;

	logic tmr_start;
	logic [10:0] tmr_delay;
	logic tmr_done;

	cam_init_sequencer cam_init_sequencer_i (
		.clk_25M   (clk_25M),
		.rst_n     (rst_n),
		.wr_valid  (wr_valid),
		.wr_req    (wr_req),
		.wr_ready  (wr_ready),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.init_done (init_done)
	);

	sccb_ctrl sccb_ctrl_i (
		.clk_25M   (clk_25M),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.load      (load),
		.shift     (shift),
		.cur_bit   (cur_bit),
		.last_bit  (last_bit),
		.tmr_start (tmr_start),
		.tmr_delay (tmr_delay),
		.tmr_done  (tmr_done),
		.scl       (scl),
		.sda       (sda),
		.busy      (busy)
	);

	sccb_frame_shifter sccb_frame_shifter_i (
		.clk_25M  (clk_25M),
		.rst_n    (rst_n),
		.load     (load),
		.req      (req),
		.shift    (shift),
		.cur_bit  (cur_bit),
		.last_bit (last_bit)
	);

	sccb_bit_timer sccb_bit_timer_i (
		.clk_25M (clk_25M),
		.rst_n   (rst_n),
		.start   (tmr_start),
		.delay   (tmr_delay),
		.done    (tmr_done)
	);

endmodule

//--- rtl/sccb_ctrl.sv
`timescale 1ns/1ns

module sccb_ctrl (
	input  logic        clk_25M,
	input  logic        rst_n,
	input  logic        req_valid,
	output logic        req_ready,
	output logic        load,
	output logic        shift,
	input  logic        cur_bit,
	input  logic        last_bit,
	output logic        tmr_start,
	output logic [10:0] tmr_delay,
	input  logic        tmr_done,
	output logic        scl,
	output logic        sda,
	output logic        busy
);
	import sccb_pkg::*;

	ctrl_state_t state;

	assign req_ready = (state == ST_IDLE);
	assign load      = req_valid & req_ready;
	// Advance to the next bit at the end of every cell but the last
	assign shift     = (state == ST_BIT_LOW) & tmr_done & ~last_bit;

	always_ff @(posedge clk_25M) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			scl <= 1'b1;
			sda <= 1'b1;
			busy <= 1'b0;
			tmr_start <= 1'b0;
		end else begin
			tmr_start <= 1'b0;
			case (state)
				ST_IDLE: if (req_valid) begin
					sda <= 1'b1;
					busy <= 1'b1;
					tmr_start <= 1'b1;
					tmr_delay <= T_SETUP;
					state <= ST_SETUP;
				end
				ST_SETUP: if (tmr_done) begin
					sda <= 1'b0; // Start condition with scl still high
					tmr_start <= 1'b1;
					tmr_delay <= T_START;
					state <= ST_START_HOLD;
				end
				ST_START_HOLD: if (tmr_done) begin
					scl <= 1'b0;
					tmr_start <= 1'b1;
					tmr_delay <= T_LOW;
					state <= ST_START_LOW;
				end
				ST_START_LOW: if (tmr_done) begin
					state <= ST_BIT_LOAD;
				end
				ST_BIT_LOAD: begin
					sda <= cur_bit; // Data changes with scl low
					tmr_start <= 1'b1;
					tmr_delay <= T_LOW;
					state <= ST_BIT_SETUP;
				end
				ST_BIT_SETUP: if (tmr_done) begin
					scl <= 1'b1;
					tmr_start <= 1'b1;
					tmr_delay <= T_HIGH;
					state <= ST_BIT_HIGH;
				end
				ST_BIT_HIGH: if (tmr_done) begin
					scl <= 1'b0;
					tmr_start <= 1'b1;
					tmr_delay <= last_bit ? T_LAST_LOW : T_LOW;
					state <= ST_BIT_LOW;
				end
				ST_BIT_LOW: if (tmr_done) begin
					if (last_bit) begin
						scl <= 1'b1; // sda is the 0 don't-care bit here
						tmr_start <= 1'b1;
						tmr_delay <= T_STOP_HOLD;
						state <= ST_STOP_HOLD;
					end else begin
						state <= ST_BIT_LOAD;
					end
				end
				ST_STOP_HOLD: if (tmr_done) begin
					sda <= 1'b1; // Stop condition
					tmr_start <= 1'b1;
					tmr_delay <= T_BUS_FREE;
					state <= ST_BUS_FREE;
				end
				ST_BUS_FREE: if (tmr_done) begin
					busy <= 1'b0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// With scl high, sda may move only for start or stop
	a_sda_stable: assert property (
		@(posedge clk_25M) disable iff (!rst_n)
		($changed(sda) && scl) |-> (state == ST_START_HOLD || state == ST_BUS_FREE)
	);

endmodule

//--- rtl/sccb_frame_shifter.sv
`timescale 1ns/1ns

module sccb_frame_shifter (
	input  logic                  clk_25M,
	input  logic                  rst_n,
	input  logic                  load,
	input  sccb_pkg::sccb_write_t req,
	input  logic                  shift,
	output logic                  cur_bit,
	output logic                  last_bit
);
	import sccb_pkg::*;

	sccb_frame_u frame_q;
	logic [4:0] bits_left; // Bits still to come after cur_bit

	// Frame word shifts left after load
	always_ff @(posedge clk_25M) begin
		if (load) begin
			frame_q.phases.id_ph   <= {SCCB_DEV_ID, 1'b0};
			frame_q.phases.addr_ph <= {req.reg_addr, 1'b0};
			frame_q.phases.data_ph <= {req.reg_data, 1'b0};
		end else if (shift) begin
			frame_q.raw <= {frame_q.raw[FRAME_BITS-2:0], 1'b0}; // MSB first
		end
	end

	always_ff @(posedge clk_25M) begin
		if (!rst_n) begin
			bits_left <= '0;
		end else if (load) begin
			bits_left <= 5'(FRAME_BITS - 1);
		end else if (shift && bits_left != 5'd0) begin
			bits_left <= bits_left - 5'd1;
		end
	end

	assign cur_bit  = frame_q.raw[FRAME_BITS-1];
	assign last_bit = (bits_left == 5'd0);

	// Controller must stop shifting at the final bit
	a_no_overshift: assert property (
		@(posedge clk_25M) disable iff (!rst_n)
		shift |-> !last_bit
	);

endmodule

//--- rtl/sccb_pkg.sv
package sccb_pkg;

	// Bus timing loads, in clk_25M cycles
	localparam logic [10:0] T_SETUP     = 11'd32;
	localparam logic [10:0] T_START     = 11'd124;
	localparam logic [10:0] T_LOW       = 11'd62;
	localparam logic [10:0] T_HIGH      = 11'd124;
	localparam logic [10:0] T_LAST_LOW  = 11'd124;
	localparam logic [10:0] T_STOP_HOLD = 11'd124;
	localparam logic [10:0] T_BUS_FREE  = 11'd248;

	localparam logic [7:0] SCCB_DEV_ID = 8'h42; // Camera write ID
	localparam int FRAME_BITS = 27;              // 3 phases of 9 bits

	typedef struct packed {
		logic [7:0] reg_addr;
		logic [7:0] reg_data;
	} sccb_write_t;

	// Byte plus trailing don't-care bit per phase
	typedef struct packed {
		logic [8:0] id_ph;
		logic [8:0] addr_ph;
		logic [8:0] data_ph;
	} sccb_phases_t;

	typedef union packed {
		sccb_phases_t phases;
		logic [FRAME_BITS-1:0] raw;
	} sccb_frame_u;

	localparam int INIT_LEN = 4;
	localparam int TBL_IDX_W = $clog2(INIT_LEN);
	localparam int INIT_IDX_W = TBL_IDX_W + 1; // Must also hold INIT_LEN itself

	localparam sccb_write_t INIT_TABLE [0:INIT_LEN-1] = '{
		'{reg_addr: 8'h12, reg_data: 8'h80}, // COM7 soft reset
		'{reg_addr: 8'h11, reg_data: 8'h01}, // Clock prescaler
		'{reg_addr: 8'h0C, reg_data: 8'h04}, // COM3
		'{reg_addr: 8'h40, reg_data: 8'hD0}  // COM15 full range RGB565
	};

	typedef enum logic [3:0] {
		ST_IDLE, ST_SETUP, ST_START_HOLD, ST_START_LOW, ST_BIT_LOAD,
		ST_BIT_SETUP, ST_BIT_HIGH, ST_BIT_LOW, ST_STOP_HOLD, ST_BUS_FREE
	} ctrl_state_t;

endpackage

//--- sim/sccb_bus_model.sv
`timescale 1ns/1ns

module sccb_bus_model (
	input  logic        clk,
	input  logic        scl,
	input  logic        sda,
	output logic [26:0] frame,      // Last complete frame
	output int          frame_bits, // Bit cells seen in that frame
	output int          frame_cnt
);

	logic scl_q = 1'b1;
	logic sda_q = 1'b1;
	logic in_frame = 1'b0;
	logic pend = 1'b0;    // Sampled on scl rise, kept only if scl falls again
	logic bit_val = 1'b0;
	logic [26:0] shreg = '0;
	int nbits = 0;

	initial begin
		frame = '0;
		frame_bits = 0;
		frame_cnt = 0;
	end

	// Bus lines are stable at the falling clock edge
	always @(negedge clk) begin
		if (scl && scl_q && sda_q && !sda) begin
			in_frame = 1'b1; // Start
			pend = 1'b0;
			nbits = 0;
		end else if (scl && scl_q && !sda_q && sda) begin
			if (in_frame) begin
				frame = shreg; // Stop closes the frame
				frame_bits = nbits;
				frame_cnt = frame_cnt + 1;
			end
			in_frame = 1'b0;
		end else if (in_frame && scl && !scl_q) begin
			pend = 1'b1;
			bit_val = sda;
		end else if (in_frame && !scl && scl_q && pend) begin
			shreg = {shreg[25:0], bit_val};
			nbits = nbits + 1;
			pend = 1'b0;
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

//--- sim/sccb_cfg_tb.sv
`timescale 1ns/1ns

module sccb_cfg_tb;
	import sccb_pkg::*;

	localparam int MAX_LINES = 16;
	localparam int CYCLES_PER_FRAME = 10000;
	// Camera write ID and init entries as the camera should receive them
	localparam logic [7:0] EXP_ID = 8'h42;
	localparam logic [15:0] EXP_INIT [0:3] = '{16'h1280, 16'h1101, 16'h0C04, 16'h40D0};

	logic clk_25M;
	logic rst_n;
	logic wr_valid;
	sccb_write_t wr_req;
	logic wr_ready;
	logic scl;
	logic sda;
	logic busy;
	logic init_done;

	logic [26:0] bus_frame;
	int bus_bits;
	int bus_cnt;

	logic [23:0] tests [0:MAX_LINES-1]; // reg_addr, reg_data, gap
	int n_tests = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int gating_errs = 0;
	int cycles = 0;
	int cycle_limit = 1000000;
	integer seed;

	sccb_cfg_top sccb_cfg_top_i (.*);

	sccb_bus_model bus_model_i (
		.clk        (clk_25M),
		.scl        (scl),
		.sda        (sda),
		.frame      (bus_frame),
		.frame_bits (bus_bits),
		.frame_cnt  (bus_cnt)
	);

	task automatic compare(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val, inout bit ok);
		if (exp_val !== act_val) begin
			$display("FAILED %s expected %0h actual %0h", name, exp_val, act_val);
			ok = 1'b0;
		end
	endtask

	task automatic report_test(input string name, input bit ok);
		if (ok) begin
			pass_cnt++;
			$display("%s ok", name);
		end else begin
			fail_cnt++;
			$display("%s had errors", name);
		end
	endtask

	initial begin
		clk_25M = 1'b0;
		forever #20 clk_25M = ~clk_25M; // 25 MHz
	end

	always @(posedge clk_25M) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	// wr_ready waits for all table frames, init_done for the last table request
	always @(negedge clk_25M) begin
		if (rst_n && wr_ready && (!init_done || bus_cnt < INIT_LEN))
			gating_errs++;
		if (rst_n && init_done && bus_cnt < INIT_LEN - 1)
			gating_errs++;
	end

	initial begin : frame_checker
		int k;
		bit ok;
		string name;
		logic [15:0] exp_wr;
		logic [26:0] exp_frame;
		k = 0;
		forever begin
			@(bus_cnt);
			if (k < INIT_LEN + n_tests) begin
				if (k < INIT_LEN) begin
					exp_wr = EXP_INIT[k];
					name = $sformatf("init_%0d", k);
				end else begin
					exp_wr = tests[k - INIT_LEN][23:8];
					name = $sformatf("write_%0d", k - INIT_LEN);
				end
				// Each byte is followed by a 0 don't-care bit
				exp_frame = {EXP_ID, 1'b0, exp_wr[15:8], 1'b0, exp_wr[7:0], 1'b0};
				ok = 1'b1;
				compare(name, 32'(exp_frame), 32'(bus_frame), ok);
				compare(name, 32'd27, 32'(bus_bits), ok);
				report_test(name, ok);
			end else begin
				$display("Unexpected extra frame %0d seen on the bus", k);
				fail_cnt++;
			end
			k++;
		end
	end

	initial begin : stimulus
		int gap;
		bit ok;
		rst_n = 1'b0;
		wr_valid = 1'b0;
		wr_req = '0;
		seed = 32'hb1fb;
		for (int i = 0; i < MAX_LINES; i++)
			tests[i] = '1; // Gap byte above 3 marks an unused slot
		$readmemh("sim/sccb_tests.mem", tests);
		while (n_tests < MAX_LINES && tests[n_tests][7:0] <= 8'd3)
			n_tests++;
		cycle_limit = (INIT_LEN + n_tests + 2) * CYCLES_PER_FRAME;

		ok = 1'b1;
		repeat (8) begin
			@(negedge clk_25M);
			compare("reset", 32'b11000, 32'({scl, sda, busy, wr_ready, init_done}), ok);
		end
		report_test("reset", ok);
		rst_n = 1'b1;

		// First request arrives while the init table is still going out
		for (int i = 0; i < n_tests; i++) begin
			gap = int'(tests[i][7:0]);
			if (gap == 0)
				gap = 1 + int'($unsigned($random(seed)) % 32'd3);
			repeat (gap) @(negedge clk_25M);
			wr_valid = 1'b1;
			wr_req = tests[i][23:8];
			while (!wr_ready)
				@(negedge clk_25M);
			@(negedge clk_25M); // Transfer on the rising edge in between
			wr_valid = 1'b0;
		end
		while (busy)
			@(negedge clk_25M);
		repeat (4) @(negedge clk_25M);

		ok = 1'b1;
		compare("frame_count", 32'(INIT_LEN + n_tests), 32'(bus_cnt), ok);
		report_test("frame_count", ok);
		ok = 1'b1;
		compare("gating", 32'd0, 32'(gating_errs), ok);
		compare("gating", 32'd1, 32'(init_done), ok);
		report_test("gating", ok);

		$display("Tests: %0d ok, %0d with errors", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- sim/sccb_tests.mem
// Columns: reg_addr (2 hex digits), reg_data (2 hex digits), idle gap (2 hex digits)
// A gap of 00 is replaced by a random gap of 1 to 3 cycles
3a0402
3d8800
1e0703
171401
180200
328002
8c0000
703a03

//--- verilog.f
rtl/sccb_pkg.sv
rtl/sccb_bit_timer.sv
rtl/sccb_frame_shifter.sv
rtl/sccb_ctrl.sv
rtl/cam_init_sequencer.sv
rtl/sccb_cfg_top.sv
sim/sccb_bus_model.sv
sim/sccb_cfg_tb.sv
